// File: Makefile
VERILATOR  ?= verilator
TOP        := dec_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+src
src/dec_pkg.sv
src/dec_col_if.sv
src/dec_ctrl.sv
src/dec_row_shift.sv
src/dec_inv_sbox.sv
src/dec_column.sv
src/dec_state.sv
src/aes_decipher.sv
tests/dec_asserts.sv
tests/dec_tb.sv

// File: src/aes_decipher.sv
/*
 * AES block decipher core, one round per cycle
 * Round keys come from an external key store indexed by round
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module aes_decipher
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    next,
  input  logic                    keylen,
  output logic [`DEC_ROUND_W-1:0] round,
  input  logic [`DEC_BLOCK_W-1:0] round_key,
  input  logic [`DEC_BLOCK_W-1:0] block,
  output logic [`DEC_BLOCK_W-1:0] new_block,
  output logic                    ready
);

  logic                    load;
  logic                    advance;
  logic [`DEC_BLOCK_W-1:0] state;

  dec_col_if cols ();

  // --------------------------------------------------------------------------
  // Control, feeder, column units and state
  // --------------------------------------------------------------------------
  dec_ctrl u_ctrl
  (
    .clk     (clk),
    .reset_n (reset_n),
    .next    (next),
    .keylen  (keylen),
    .round   (round),
    .ready   (ready),
    .load    (load),
    .advance (advance),
    .cols    (cols)
  );

  dec_row_shift u_row_shift
  (
    .state     (state),
    .round_key (round_key),
    .cols      (cols)
  );

  for (genvar c = 0; c < `DEC_COLS; c++)
  begin : g_col
    dec_column #(.COL(c)) u_column (.cols(cols));
  end

  dec_state u_state
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .load      (load),
    .advance   (advance),
    .block     (block),
    .round_key (round_key),
    .cols      (cols),
    .state     (state)
  );

  // Plaintext is valid while ready is high
  assign new_block = state;

endmodule

// File: src/dec_col_if.sv
/*
 * Column bus of the AES decipher core
 * Carries the shifted words, key words and round results per column
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

interface dec_col_if;

  // State words after InvShiftRows, one per column
  dec_pkg::col_word_u shifted [`DEC_COLS];
  // Round key split into column words
  dec_pkg::col_word_u key_word [`DEC_COLS];
  // High in main rounds, low in the final round
  logic               use_mix;
  // Next state words from the column units
  dec_pkg::col_word_u result [`DEC_COLS];

  modport feed  (output shifted, output key_word);
  modport ctrl  (output use_mix);
  modport col   (input shifted, input key_word, input use_mix, output result);
  modport drain (input result);

endinterface

// File: src/dec_column.sv
/*
 * One AES decipher state column
 * InvSubBytes, AddRoundKey and InvMixColumns in a single cycle
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module dec_column
#(
  parameter int COL = 0
)
(
  dec_col_if.col cols
);

  localparam int ROWS = `DEC_WORD_W / 8;

  logic [7:0]         sub_byte [ROWS];
  dec_pkg::col_word_u sub;
  dec_pkg::col_word_u added;
  dec_pkg::col_word_u mixed;

  // Multiply by a 4-bit constant k from the sums of b, 2b, 4b and 8b
  function automatic logic [7:0] gf_mulk(input logic [7:0] b, input logic [3:0] k);
    logic [7:0] b2;
    logic [7:0] b4;
    logic [7:0] b8;
    b2 = dec_pkg::gf_mul2(b);
    b4 = dec_pkg::gf_mul2(b2);
    b8 = dec_pkg::gf_mul2(b4);
    return ({8{k[0]}} & b) ^ ({8{k[1]}} & b2) ^ ({8{k[2]}} & b4) ^ ({8{k[3]}} & b8);
  endfunction

  // One inverse S-box per row byte
  for (genvar r = 0; r < ROWS; r++)
  begin : g_sbox
    dec_inv_sbox u_inv_sbox
    (
      .in_byte  (cols.shifted[COL].bytes[r]),
      .out_byte (sub_byte[r])
    );
  end

  // --------------------------------------------------------------------------
  // AddRoundKey on the whole word, InvMixColumns byte by byte
  // --------------------------------------------------------------------------
  always_comb
  begin
    for (int r = 0; r < ROWS; r++)
      sub.bytes[r] = sub_byte[r];
    added.word = sub.word ^ cols.key_word[COL].word;
    // Circulant 0e 0b 0d 09
    for (int r = 0; r < ROWS; r++)
    begin
      mixed.bytes[r] = gf_mulk(added.bytes[r], 4'he)
                     ^ gf_mulk(added.bytes[(r + 1) % ROWS], 4'hb)
                     ^ gf_mulk(added.bytes[(r + 2) % ROWS], 4'hd)
                     ^ gf_mulk(added.bytes[(r + 3) % ROWS], 4'h9);
    end
  end

  // Final round skips the mix
  assign cols.result[COL] = cols.use_mix ? mixed : added;

endmodule

// File: src/dec_ctrl.sv
/*
 * AES decipher round sequencer
 * Counts rounds down from N to 0 and holds the ready level
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module dec_ctrl
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    next,
  input  logic                    keylen,
  output logic [`DEC_ROUND_W-1:0] round,
  output logic                    ready,
  output logic                    load,
  output logic                    advance,
  dec_col_if.ctrl                 cols
);

  localparam logic [`DEC_ROUND_W-1:0] ROUNDS_128 = `DEC_ROUND_W'(`DEC_ROUNDS_128);
  localparam logic [`DEC_ROUND_W-1:0] ROUNDS_256 = `DEC_ROUND_W'(`DEC_ROUNDS_256);
  localparam logic [`DEC_ROUND_W-1:0] LAST_MAIN  = `DEC_ROUND_W'(1);

  typedef enum logic [1:0] {IDLE, LOAD, MAIN, FINAL} ctrl_state_e;

  ctrl_state_e                ctrl_state;
  logic [`DEC_ROUND_W-1:0]    num_rounds;

  // keylen 1 selects the 256-bit schedule
  assign num_rounds = keylen ? ROUNDS_256 : ROUNDS_128;

  // --------------------------------------------------------------------------
  // Sequencer and round counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ctrl_state <= IDLE;
      round      <= '0;
      ready      <= 1'b1;
    end
    else
    begin
      case (ctrl_state)
        IDLE:
        begin
          // Start only from the idle level, keylen sampled here
          if (next)
          begin
            round      <= num_rounds;
            ready      <= 1'b0;
            ctrl_state <= LOAD;
          end
        end
        LOAD:
        begin
          round      <= round - 1'b1;
          ctrl_state <= MAIN;
        end
        MAIN:
        begin
          round <= round - 1'b1;
          // Round 1 is the last one with InvMixColumns
          if (round == LAST_MAIN)
            ctrl_state <= FINAL;
        end
        default:
        begin
          ready      <= 1'b1;
          ctrl_state <= IDLE;
        end
      endcase
    end
  end

  // Strobes to the state register and the column units
  assign load         = (ctrl_state == LOAD);
  assign advance      = (ctrl_state == MAIN) || (ctrl_state == FINAL);
  assign cols.use_mix = (ctrl_state == MAIN);

endmodule

// File: src/dec_defines.svh
/*
 * AES decipher core widths and round counts
 * Shared by the package, the interface and every RTL block
 */
`ifndef DEC_DEFINES_SVH
`define DEC_DEFINES_SVH

// Block and round key width
`define DEC_BLOCK_W 128
// One state column, four bytes
`define DEC_WORD_W 32
`define DEC_COLS 4
// Round number as shown to the key store
`define DEC_ROUND_W 4
// Round counts per key length
`define DEC_ROUNDS_128 10
`define DEC_ROUNDS_256 14

`endif

// File: src/dec_inv_sbox.sv
/*
 * AES inverse S-box for one byte
 * Inverse affine map, then the GF(2^8) inverse as x^254
 */
`timescale 1ns/1ns

module dec_inv_sbox
(
  input  logic [7:0] in_byte,
  output logic [7:0] out_byte
);

  logic [7:0] aff;
  logic [7:0] x2, x3, x6, x12, x15, x30, x60, x120, x240, x252;

  // Shift and add multiply over GF(2^8)
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = '0;
    p   = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc ^= p;
      p = dec_pkg::gf_mul2(p);
    end
    return acc;
  endfunction

  // Inverse affine, rotate left by 1, 3 and 6 plus constant 05
  assign aff = {in_byte[6:0], in_byte[7]} ^ {in_byte[4:0], in_byte[7:5]}
             ^ {in_byte[1:0], in_byte[7:2]} ^ 8'h05;

  // Addition chain to x^254, zero maps to zero
  assign x2   = gf_mul(aff, aff);
  assign x3   = gf_mul(x2, aff);
  assign x6   = gf_mul(x3, x3);
  assign x12  = gf_mul(x6, x6);
  assign x15  = gf_mul(x12, x3);
  assign x30  = gf_mul(x15, x15);
  assign x60  = gf_mul(x30, x30);
  assign x120 = gf_mul(x60, x60);
  assign x240 = gf_mul(x120, x120);
  assign x252 = gf_mul(x240, x12);
  assign out_byte = gf_mul(x252, x2);

endmodule

// File: src/dec_pkg.sv
/*
 * AES decipher types and GF(2^8) helpers
 * Column word union and the xtime function
 */
`include "dec_defines.svh"

package dec_pkg;

  // One state column, seen as a whole word or as four row bytes
  // Byte 0 is the most significant byte and holds row 0
  typedef union packed
  {
    logic [`DEC_WORD_W-1:0]             word;
    logic [0:`DEC_WORD_W/8-1][7:0]      bytes;
  } col_word_u;

  // xtime, multiply by x modulo the AES polynomial
  function automatic logic [7:0] gf_mul2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

endpackage

// File: src/dec_row_shift.sv
/*
 * InvShiftRows feeder
 * Rotates the state rows and hands each column its word and key word
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module dec_row_shift
(
  input  logic [`DEC_BLOCK_W-1:0] state,
  input  logic [`DEC_BLOCK_W-1:0] round_key,
  dec_col_if.feed                 cols
);

  localparam int ROWS = `DEC_WORD_W / 8;

  // --------------------------------------------------------------------------
  // Column c row r takes column (c - r) mod 4 row r
  // --------------------------------------------------------------------------
  always_comb
  begin
    for (int c = 0; c < `DEC_COLS; c++)
    begin
      // Column 0 sits in the top bits of the key
      cols.key_word[c].word = round_key[`DEC_BLOCK_W-1 - `DEC_WORD_W*c -: `DEC_WORD_W];
      for (int r = 0; r < ROWS; r++)
      begin
        // Row r moves right by r columns
        cols.shifted[c].bytes[r] =
          state[`DEC_BLOCK_W-1 - `DEC_WORD_W*((c - r + `DEC_COLS) % `DEC_COLS) - 8*r -: 8];
      end
    end
  end

endmodule

// File: src/dec_state.sv
/*
 * AES decipher state register
 * Initial AddRoundKey on load, column results on advance
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module dec_state
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    load,
  input  logic                    advance,
  input  logic [`DEC_BLOCK_W-1:0] block,
  input  logic [`DEC_BLOCK_W-1:0] round_key,
  dec_col_if.drain                cols,
  output logic [`DEC_BLOCK_W-1:0] state
);

  logic [`DEC_BLOCK_W-1:0] drained;

  // Gather the column words, column 0 on top
  always_comb
  begin
    for (int c = 0; c < `DEC_COLS; c++)
      drained[`DEC_BLOCK_W-1 - `DEC_WORD_W*c -: `DEC_WORD_W] = cols.result[c].word;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= '0;
    else if (load)
      state <= block ^ round_key;
    else if (advance)
      state <= drained;
  end

endmodule

// File: tests/dec_asserts.sv
/*
 * Protocol assertions for the AES decipher core
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module dec_asserts
(
  input logic                    clk,
  input logic                    reset_n,
  input logic                    next,
  input logic                    ready,
  input logic [`DEC_ROUND_W-1:0] round
);

  localparam logic [`DEC_ROUND_W-1:0] MAX_ROUND = `DEC_ROUND_W'(`DEC_ROUNDS_256);

  // Longest schedule starts at 14
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n) round <= MAX_ROUND)
    else $error("round above the longest schedule");

  // Busy from the start strobe until the final round
  a_ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
    (ready && next) |=> !ready)
    else $error("ready stayed high after a start");
  a_busy_low: assert property (@(posedge clk) disable iff (!reset_n) (round != 0) |-> !ready)
    else $error("ready high before round 0");

  a_round_step: assert property (@(posedge clk) disable iff (!reset_n)
    (!ready && round != 0) |=> (round == $past(round) - 4'd1))
    else $error("round did not step down by one");

endmodule

bind aes_decipher dec_asserts u_dec_asserts
(
  .clk     (clk),
  .reset_n (reset_n),
  .next    (next),
  .ready   (ready),
  .round   (round)
);

// File: tests/dec_tb.sv
/*
 * Directed testbench for the AES decipher core
 * Behavioral inverse cipher model, round key store and checks
 */
`timescale 1ns/1ns
`include "dec_defines.svh"

module dec_tb;

  localparam int TIMEOUT = 40;

  logic                    clk;
  logic                    reset_n;
  logic                    next;
  logic                    keylen;
  logic [`DEC_ROUND_W-1:0] round;
  logic [`DEC_BLOCK_W-1:0] round_key;
  logic [`DEC_BLOCK_W-1:0] block;
  logic [`DEC_BLOCK_W-1:0] new_block;
  logic                    ready;

  integer                  seed;
  logic [`DEC_BLOCK_W-1:0] key_table [15];
  logic [7:0]              inv_sbox_tbl [256];

  aes_decipher u_aes_decipher
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .round     (round),
    .round_key (round_key),
    .block     (block),
    .new_block (new_block),
    .ready     (ready)
  );

  // Key store follows round within the cycle
  assign round_key = key_table[round];

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] acc;
    p   = a;
    acc = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ p;
      p = p[7] ? ({p[6:0], 1'b0} ^ 8'h1b) : {p[6:0], 1'b0};
    end
    return acc;
  endfunction

  // Inverse table built by inverting the forward S-box with each GF inverse found by search
  task automatic build_inv_sbox();
    logic [7:0] inv;
    logic [7:0] s;
    for (int y = 0; y < 256; y++)
    begin
      inv = 8'h00;
      for (int z = 1; z < 256; z++)
        if (gf_mult(8'(y), 8'(z)) == 8'h01)
          inv = 8'(z);
      s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
      inv_sbox_tbl[s] = 8'(y);
    end
  endtask

  // Byte i of a block sits in column i/4 and row i%4
  function automatic logic [127:0] model_decrypt(input logic [127:0] ct, input logic kl);
    logic [7:0]   st  [16];
    logic [7:0]   tmp [16];
    logic [127:0] res;
    int           n;
    n = kl ? `DEC_ROUNDS_256 : `DEC_ROUNDS_128;
    for (int i = 0; i < 16; i++)
      st[i] = ct[127 - 8*i -: 8] ^ key_table[n][127 - 8*i -: 8];
    for (int rnd = n - 1; rnd >= 0; rnd--)
    begin
      // InvShiftRows, InvSubBytes and AddRoundKey
      for (int i = 0; i < 16; i++)
        tmp[i] = inv_sbox_tbl[st[4*(((i/4) - (i%4) + 4) % 4) + i%4]]
               ^ key_table[rnd][127 - 8*i -: 8];
      // InvMixColumns on all but the final round
      for (int i = 0; i < 16; i++)
        st[i] = (rnd == 0) ? tmp[i] :
                gf_mult(tmp[i], 8'h0e) ^ gf_mult(tmp[4*(i/4) + (i+1)%4], 8'h0b)
              ^ gf_mult(tmp[4*(i/4) + (i+2)%4], 8'h0d) ^ gf_mult(tmp[4*(i/4) + (i+3)%4], 8'h09);
    end
    for (int i = 0; i < 16; i++)
      res[127 - 8*i -: 8] = st[i];
    return res;
  endfunction

  function automatic logic [127:0] rand_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus and checks
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // Counts edges after the start edge and expects round to step down each cycle
  task automatic wait_ready(input string name, input int n_rounds, input int poke_at);
    int edges;
    edges = 0;
    while (!ready)
    begin
      @(negedge clk);
      next  = 1'b0;
      edges = edges + 1;
      // Second start attempt while busy
      if (edges == poke_at)
      begin
        next   = 1'b1;
        keylen = ~keylen;
        block  = ~block;
      end
      if (edges > TIMEOUT)
      begin
        $display("Timeout in %s, ready never rose", name);
        $display("Test failed");
        $fatal(1, "ready timeout");
      end
      else if (!ready)
        check_value({name, " round"}, 128'(n_rounds - edges), 128'(round));
    end
    check_value({name, " ready edges"}, 128'(n_rounds + 1), 128'(edges));
  endtask

  task automatic decrypt_and_check(input string name, input logic [127:0] blk,
                                   input logic kl, input int poke_at);
    logic [127:0] expected;
    int           n;
    expected = model_decrypt(blk, kl);
    n        = kl ? `DEC_ROUNDS_256 : `DEC_ROUNDS_128;
    block    = blk;
    keylen   = kl;
    next     = 1'b1;
    @(negedge clk);
    next = 1'b0;
    check_value({name, " first round"}, 128'(n), 128'(round));
    wait_ready(name, n, poke_at);
    check_value(name, expected, new_block);
  endtask

  task automatic test_reset();
    check_value("reset ready", 128'(1), 128'(ready));
    check_value("reset round", 128'(0), 128'(round));
    check_value("reset new_block", 128'(0), new_block);
  endtask

  task automatic test_busy_next();
    logic [127:0] blk;
    logic [127:0] expected;
    blk      = rand_block();
    expected = model_decrypt(blk, 1'b0);
    decrypt_and_check("busy next", blk, 1'b0, 3);
    for (int i = 0; i < 5; i++)
    begin
      @(negedge clk);
      check_value("busy next hold", expected, new_block);
    end
  endtask

  initial
  begin
    seed    = 90;
    reset_n = 1'b0;
    next    = 1'b0;
    keylen  = 1'b0;
    block   = '0;
    for (int i = 0; i < 15; i++)
      key_table[i] = rand_block();
    build_inv_sbox();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    test_reset();
    decrypt_and_check("aes128", rand_block(), 1'b0, 0);
    decrypt_and_check("aes256", rand_block(), 1'b1, 0);
    test_busy_next();
    for (int i = 0; i < 5; i++)
      decrypt_and_check($sformatf("back to back %0d", i), rand_block(), (i % 2) == 1, 0);
    $display("Test completed successfully");
    $finish;
  end

endmodule
